// File: Makefile
TOP = snes_pad_sys_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f snes_pad_sys.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// File: hdl/button_events.sv
`timescale 1ns/1ps

module button_events
(
	input  logic                                         clk,
	input  logic                                         rst,
	input  snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] frame,
	input  logic                                         frame_valid,
	output snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] pressed,
	output snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] released,
	output logic                                         events_valid
);

	// Frame seen at the last frame_valid
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] prev;

	//////////////////////////////
	// Edge masks per pad
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			prev <= '0;
			pressed <= '0;
			released <= '0;
			events_valid <= 1'b0;
		end
		else
		begin
			events_valid <= frame_valid;
			if (frame_valid)
			begin
				for (int p = 0; p < snes_pkg::NUM_PADS; p++)
				begin
					// Held now but not before
					pressed[p] <= frame[p] & ~prev[p];
					// Held before but not now
					released[p] <= prev[p] & ~frame[p];
				end
				prev <= frame;
			end
		end
	end

endmodule

// File: hdl/poll_timer.sv
`timescale 1ns/1ps

module poll_timer #(
	parameter int POLL_CYCLES = snes_pkg::POLL_CYCLES_DEFAULT
)
(
	input  logic clk,
	input  logic rst,
	output logic poll
);

	logic [snes_pkg::TIMER_WIDTH-1:0] count;
	logic                             wrap;

	// Last count of the period
	assign wrap = (count == snes_pkg::TIMER_WIDTH'(POLL_CYCLES - 1));

	//////////////////////////////
	// Period counter
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			count <= '0;
			poll <= 1'b0;
		end
		else
		begin
			// Strobe is registered so the first one lands a full period after reset
			poll <= wrap;
			if (wrap)
			begin
				count <= '0;
			end
			else
			begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// File: hdl/snes_pad_reader.sv
`timescale 1ns/1ps

module snes_pad_reader
(
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         poll,
	input  logic [snes_pkg::NUM_PADS-1:0]                pad_data,
	output logic                                         pad_latch,
	output logic                                         pad_clock,
	output snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] frame,
	output logic                                         frame_valid
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_LATCH,
		ST_GAP,
		ST_PULSE
	} state_t;

	state_t                                      state;
	logic [snes_pkg::PHASE_WIDTH-1:0]            phase;
	logic [snes_pkg::BIT_WIDTH-1:0]              bit_idx;
	logic                                        phase_end;
	logic                                        last_bit;
	logic                                        sample;

	logic [snes_pkg::NUM_PADS-1:0]               data_meta;
	logic [snes_pkg::NUM_PADS-1:0]               data_sync;

	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] work;
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] work_next;

	//////////////////////////////
	// Data line synchronizers
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		data_meta <= pad_data;
		data_sync <= data_meta;
	end

	//////////////////////////////
	// Phase and bit decode
	//////////////////////////////

	// Latch phase is longer than the clock half periods
	always_comb
	begin
		if (state == ST_LATCH)
		begin
			phase_end = (phase == snes_pkg::PHASE_WIDTH'(snes_pkg::LATCH_CYCLES - 1));
		end
		else
		begin
			phase_end = (phase == snes_pkg::PHASE_WIDTH'(snes_pkg::HALF_CYCLES - 1));
		end
	end

	assign last_bit = (bit_idx == snes_pkg::BIT_WIDTH'(snes_pkg::BUTTON_COUNT - 1));

	// First cycle of every gap follows a falling latch or clock edge
	assign sample = (state == ST_GAP) && (phase == '0);

	// Pad drives active low, so the inverted sample goes in at the bottom
	always_comb
	begin
		for (int p = 0; p < snes_pkg::NUM_PADS; p++)
		begin
			work_next[p] = snes_pkg::pad_buttons_t'(
				{work[p][snes_pkg::BUTTON_COUNT-2:0], ~data_sync[p]});
		end
	end

	always_ff @(posedge clk)
	begin
		if (sample)
		begin
			work <= work_next;
		end
	end

	//////////////////////////////
	// Frame sequencer
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= ST_IDLE;
			phase <= '0;
			bit_idx <= '0;
			pad_latch <= 1'b0;
			pad_clock <= 1'b0;
			frame <= '0;
			frame_valid <= 1'b0;
		end
		else
		begin
			frame_valid <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					// Polls during a frame never reach this state
					if (poll)
					begin
						state <= ST_LATCH;
						phase <= '0;
						bit_idx <= '0;
						pad_latch <= 1'b1;
					end
				end
				ST_LATCH:
				begin
					if (phase_end)
					begin
						state <= ST_GAP;
						phase <= '0;
						pad_latch <= 1'b0;
					end
					else
					begin
						phase <= phase + 1'b1;
					end
				end
				ST_GAP:
				begin
					if (sample && last_bit)
					begin
						// Last button is in, publish the whole frame at once
						state <= ST_IDLE;
						phase <= '0;
						frame <= work_next;
						frame_valid <= 1'b1;
					end
					else if (phase_end)
					begin
						state <= ST_PULSE;
						phase <= '0;
						pad_clock <= 1'b1;
					end
					else
					begin
						phase <= phase + 1'b1;
					end
				end
				ST_PULSE:
				begin
					// Pad moves to its next bit on the rising clock
					if (phase_end)
					begin
						state <= ST_GAP;
						phase <= '0;
						bit_idx <= bit_idx + 1'b1;
						pad_clock <= 1'b0;
					end
					else
					begin
						phase <= phase + 1'b1;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hdl/snes_pad_sys.sv
`timescale 1ns/1ps

module snes_pad_sys #(
	parameter int POLL_CYCLES = snes_pkg::POLL_CYCLES_DEFAULT
)
(
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic [snes_pkg::NUM_PADS-1:0]                pad_data,
	output logic                                         pad_latch,
	output logic                                         pad_clock,
	output snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] frame,
	output logic                                         frame_valid,
	output snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] pressed,
	output snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] released,
	output logic                                         events_valid
);

	logic poll;

	// One frame request per polling period
	poll_timer #(
		.POLL_CYCLES (POLL_CYCLES)
	) i_poll_timer (
		.clk  (clk),
		.rst  (rst),
		.poll (poll)
	);

	// Shared latch and clock, one data line per pad
	snes_pad_reader i_snes_pad_reader (
		.clk         (clk),
		.rst         (rst),
		.poll        (poll),
		.pad_data    (pad_data),
		.pad_latch   (pad_latch),
		.pad_clock   (pad_clock),
		.frame       (frame),
		.frame_valid (frame_valid)
	);

	button_events i_button_events (
		.clk          (clk),
		.rst          (rst),
		.frame        (frame),
		.frame_valid  (frame_valid),
		.pressed      (pressed),
		.released     (released),
		.events_valid (events_valid)
	);

endmodule

// File: hdl/snes_pkg.sv
package snes_pkg;

	//////////////////////////////
	// Pad port shape
	//////////////////////////////

	// Pads sharing one latch and one clock line
	localparam int NUM_PADS = 2;

	// Buttons read per pad, trailing stream bits are skipped
	localparam int BUTTON_COUNT = 12;
	localparam int BIT_WIDTH = $clog2(BUTTON_COUNT);

	// One bit per button, 1 means held
	// Fields follow the order the pad shifts them out
	typedef struct packed {
		logic b;
		logic y;
		logic select;
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
		logic a;
		logic x;
		logic l;
		logic r;
	} pad_buttons_t;

	//////////////////////////////
	// Timing at 50 MHz
	//////////////////////////////

	localparam int LATCH_CYCLES = 600;
	localparam int HALF_CYCLES = 300;
	localparam int PHASE_WIDTH = $clog2(LATCH_CYCLES);

	// 60 Hz polling
	localparam int POLL_CYCLES_DEFAULT = 833333;
	localparam int TIMER_WIDTH = $clog2(POLL_CYCLES_DEFAULT);

endpackage

// File: snes_pad_sys.f
hdl/snes_pkg.sv
hdl/poll_timer.sv
hdl/snes_pad_reader.sv
hdl/button_events.sv
hdl/snes_pad_sys.sv
test/snes_pad_model.sv
test/snes_pad_sys_tb.sv

// File: test/snes_pad_model.sv
`timescale 1ns/1ps

module snes_pad_model
(
	input  logic                   pad_latch,
	input  logic                   pad_clock,
	input  snes_pkg::pad_buttons_t buttons,
	output logic                   data,
	output int                     shifts
);

	logic [snes_pkg::BUTTON_COUNT-1:0] held_bits;
	logic [15:0]                       load_value;
	logic [15:0]                       stream = '1;
	int                                shift_count = 0;

	//////////////////////////////
	// Parallel load value
	//////////////////////////////

	assign held_bits = buttons;

	// B goes out first, so it sits in bit 0
	always_comb
	begin
		for (int i = 0; i < snes_pkg::BUTTON_COUNT; i++)
		begin
			load_value[i] = ~held_bits[snes_pkg::BUTTON_COUNT-1-i];
		end
		// Unused trailing bits read as released
		for (int i = snes_pkg::BUTTON_COUNT; i < 16; i++)
		begin
			load_value[i] = 1'b1;
		end
	end

	//////////////////////////////
	// Shift register
	//////////////////////////////

	// Latch acts as an asynchronous load, clock shifts towards bit 0
	always @(posedge pad_clock or posedge pad_latch)
	begin
		if (pad_latch)
		begin
			stream <= load_value;
			shift_count <= 0;
		end
		else
		begin
			stream <= {1'b1, stream[15:1]};
			shift_count <= shift_count + 1;
		end
	end

	// Transparent to the buttons while the latch is high
	assign data = pad_latch ? load_value[0] : stream[0];

	// Clock pulses seen since the last latch
	assign shifts = shift_count;

endmodule

// File: test/snes_pad_sys_tb.sv
`timescale 1ns/1ps

module snes_pad_sys_tb;

	localparam int POLL_CYCLES = 10000;
	localparam int NUM_TESTS = 6;
	localparam int RESET_CYCLES = 16;
	localparam int READ_FRAMES = 2;
	localparam int EVENT_FRAMES = 6;

	logic                                            clk;
	logic                                            rst;
	logic [snes_pkg::NUM_PADS-1:0]                   pad_data;
	logic                                            pad_latch;
	logic                                            pad_clock;
	logic                                            frame_valid;
	logic                                            events_valid;
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] frame;
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] pressed;
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] released;

	// Buttons held on the pad models
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] held;
	// Reference copy of the last frame, zero after reset
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] shadow_prev = '0;
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] prev_before;
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] got_frame;
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] got_pressed;
	snes_pkg::pad_buttons_t [snes_pkg::NUM_PADS-1:0] got_released;

	int   shifts_0;
	int   shifts_1;
	int   cycle = 0;
	int   latch_rises = 0;
	int   clock_rises = 0;
	int   overlap_cycles = 0;
	logic latch_q = 1'b0;
	logic clock_q = 1'b0;

	snes_pad_sys #(
		.POLL_CYCLES (POLL_CYCLES)
	) i_snes_pad_sys (
		.clk          (clk),
		.rst          (rst),
		.pad_data     (pad_data),
		.pad_latch    (pad_latch),
		.pad_clock    (pad_clock),
		.frame        (frame),
		.frame_valid  (frame_valid),
		.pressed      (pressed),
		.released     (released),
		.events_valid (events_valid)
	);

	snes_pad_model i_pad_0 (
		.pad_latch (pad_latch),
		.pad_clock (pad_clock),
		.buttons   (held[0]),
		.data      (pad_data[0]),
		.shifts    (shifts_0)
	);

	snes_pad_model i_pad_1 (
		.pad_latch (pad_latch),
		.pad_clock (pad_clock),
		.buttons   (held[1]),
		.data      (pad_data[1]),
		.shifts    (shifts_1)
	);

	//////////////////////////////
	// Clock, watchdog, monitors
	//////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Three poll periods per test is ample
	initial
	begin
		repeat (NUM_TESTS * 3 * POLL_CYCLES) @(posedge clk);
		$display("Run did not finish within %0d clock cycles", NUM_TESTS * 3 * POLL_CYCLES);
		$display("Simulation failed");
		$fatal(1);
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	// Line edges counted away from the driving edge
	always @(negedge clk)
	begin
		if (pad_latch && !latch_q)
		begin
			latch_rises = latch_rises + 1;
		end
		if (pad_clock && !clock_q)
		begin
			clock_rises = clock_rises + 1;
		end
		if (pad_latch && pad_clock)
		begin
			overlap_cycles = overlap_cycles + 1;
		end
		latch_q = pad_latch;
		clock_q = pad_clock;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic match_buttons(input string test, input string what,
		input snes_pkg::pad_buttons_t expected, input snes_pkg::pad_buttons_t actual);
		assert (actual == expected)
		else
		begin
			$display("Fail %s %s: expected %h, actual %h", test, what, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic match_count(input string test, input string what,
		input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			$display("Fail %s %s: expected %0d, actual %0d", test, what, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Single line must be a clean low, unknown counts as wrong
	task automatic expect_low(input string test, input string what, input logic actual);
		assert (actual === 1'b0)
		else
		begin
			$display("Fail %s %s: expected 0, actual %b", test, what, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic require_true(input string test, input logic cond, input string msg);
		assert (cond)
		else
		begin
			$display("Error in %s: %s", test, msg);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic randomize_pads();
		logic [31:0] r;
		for (int p = 0; p < snes_pkg::NUM_PADS; p++)
		begin
			r = $urandom;
			held[p] = r[snes_pkg::BUTTON_COUNT-1:0];
		end
	endtask

	// Leaves the run on the cycle that carries events_valid
	task automatic collect_frame(input string test);
		int waited;
		waited = 0;
		while (!frame_valid && waited < 2 * POLL_CYCLES)
		begin
			next_cycle();
			waited++;
		end
		require_true(test, frame_valid, "frame_valid did not arrive within two poll periods");
		got_frame = frame;
		next_cycle();
		require_true(test, events_valid, "events_valid did not follow frame_valid");
		got_pressed = pressed;
		got_released = released;
		prev_before = shadow_prev;
		shadow_prev = held;
	endtask

	// Masks follow from the buttons just read and the frame before them
	task automatic verify_events(input string test);
		for (int p = 0; p < snes_pkg::NUM_PADS; p++)
		begin
			match_buttons(test, $sformatf("pressed pad %0d", p),
				held[p] & ~prev_before[p], got_pressed[p]);
			match_buttons(test, $sformatf("released pad %0d", p),
				prev_before[p] & ~held[p], got_released[p]);
		end
	endtask

	task automatic verify_idle(input string test);
		expect_low(test, "pad_latch", pad_latch);
		expect_low(test, "pad_clock", pad_clock);
		expect_low(test, "frame_valid", frame_valid);
		expect_low(test, "events_valid", events_valid);
		for (int p = 0; p < snes_pkg::NUM_PADS; p++)
		begin
			match_buttons(test, $sformatf("frame pad %0d", p), '0, frame[p]);
			match_buttons(test, $sformatf("pressed pad %0d", p), '0, pressed[p]);
			match_buttons(test, $sformatf("released pad %0d", p), '0, released[p]);
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic reset_state();
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			next_cycle();
			verify_idle("reset_state");
		end
		rst = 1'b1;
		next_cycle();
		verify_idle("reset_state");
	endtask

	task automatic frame_read();
		for (int i = 0; i < READ_FRAMES; i++)
		begin
			randomize_pads();
			collect_frame("frame_read");
			for (int p = 0; p < snes_pkg::NUM_PADS; p++)
			begin
				match_buttons("frame_read", $sformatf("pad %0d", p), held[p], got_frame[p]);
			end
			// First frame after reset reports every held button as pressed
			verify_events("frame_read");
		end
	endtask

	task automatic pads_independent();
		held[0] = '1;
		held[1] = '0;
		collect_frame("pads_independent");
		match_buttons("pads_independent", "pad 0 all held", '1, got_frame[0]);
		match_buttons("pads_independent", "pad 1 none held", '0, got_frame[1]);
		held[0] = '0;
		held[1] = '1;
		collect_frame("pads_independent");
		match_buttons("pads_independent", "pad 0 none held", '0, got_frame[0]);
		match_buttons("pads_independent", "pad 1 all held", '1, got_frame[1]);
	endtask

	task automatic line_activity();
		int latch_start;
		int clock_start;
		int overlap_start;
		latch_start = latch_rises;
		clock_start = clock_rises;
		overlap_start = overlap_cycles;
		collect_frame("line_activity");
		match_count("line_activity", "latch rises", 1, latch_rises - latch_start);
		match_count("line_activity", "clock pulses", snes_pkg::BUTTON_COUNT - 1,
			clock_rises - clock_start);
		match_count("line_activity", "clock high during latch", 0,
			overlap_cycles - overlap_start);
		match_count("line_activity", "pad 0 shifts", snes_pkg::BUTTON_COUNT - 1, shifts_0);
		match_count("line_activity", "pad 1 shifts", snes_pkg::BUTTON_COUNT - 1, shifts_1);
	endtask

	task automatic poll_period();
		int first;
		collect_frame("poll_period");
		first = cycle;
		collect_frame("poll_period");
		match_count("poll_period", "frame spacing", POLL_CYCLES, cycle - first);
	endtask

	task automatic press_release();
		for (int i = 0; i < EVENT_FRAMES; i++)
		begin
			randomize_pads();
			collect_frame("press_release");
			verify_events("press_release");
		end
	endtask

	initial
	begin
		rst = 1'b0;
		held = '0;
		void'($urandom(95));
		reset_state();
		frame_read();
		pads_independent();
		line_activity();
		poll_period();
		press_release();
		$display("Simulation passed");
		$finish;
	end

endmodule
